//--- game_pkg.sv
/*
  shared types and register map for the collision subsystem
  modules import this package for layer requests, event flags and the host bus
*/
`default_nettype none

package game_pkg;

	// bus and counter widths
	localparam int WB_DATA_W = 16;
	localparam int WB_ADDR_W = 2;
	localparam int FRAME_COUNT_W = 16;
	localparam int CTRL_BITS = 2; // one invulnerability bit per player

	typedef logic [WB_DATA_W-1:0] wb_data_t;
	typedef logic [WB_ADDR_W-1:0] wb_addr_t;
	typedef logic [FRAME_COUNT_W-1:0] frame_count_t; // frames since reset, wraps

	// host register map, word addresses
	localparam wb_addr_t REG_CONTROL = 2'd0;     // bit 0 player1, bit 1 player2 invulnerable
	localparam wb_addr_t REG_LAST_EVENTS = 2'd1; // summary of the previous frame
	localparam wb_addr_t REG_FRAME_COUNT = 2'd2; // frame counter
	// address 3 is unmapped and reads zero

	// one draw request per sprite or background layer, first field is the msb
	typedef struct packed {
		logic player1;
		logic player2;
		logic columns;
		logic wall;
		logic blast1;
		logic blast2;
		logic enemy1;
		logic enemy2;
		logic enemy3;
		logic bomb1;   // laid by player1
		logic bomb2;   // laid by player2
		logic door_idol;
		logic powerup;
		logic spikes;
	} layer_req_t;

	// collision events, also the layout of the last-frame summary register
	typedef struct packed {
		logic player1_blocked;
		logic player2_blocked;
		logic enemy1_blocked;
		logic enemy2_blocked;
		logic enemy3_blocked;
		logic enemy_blocked_any;
		logic blast_wall;
		logic player1_door;
		logic player1_powerup;
		logic player2_powerup;
		logic player1_hit;
		logic player2_hit;
		logic enemy1_kill;
		logic enemy2_kill;
		logic enemy3_kill;
		logic spare;   // always zero
	} event_t;

endpackage

`default_nettype wire

//--- layer_sampler.sv
/*
  input stage, registers all draw requests and the frame pulse on one edge
  so the collision rules always look at a single coherent pixel
*/
`timescale 1ns/1ns
`default_nettype none

module layer_sampler (
	input logic clk,
	input logic resetN,
	input game_pkg::layer_req_t layers_in,
	input logic start_of_frame,
	output game_pkg::layer_req_t sampled,
	output logic frame_start
);

	// requests and frame pulse move together, one cycle of latency
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			sampled <= '0;
			frame_start <= 1'b0;
		end
		else begin
			sampled <= layers_in;
			frame_start <= start_of_frame; // lines up with the first pixel of the frame
		end
	end

endmodule

`default_nettype wire

//--- collision_matrix.sv
/*
  combinational collision rules, one sampled pixel in, one event vector out
  invulnerability bits come from the host control register
*/
`timescale 1ns/1ns
`default_nettype none

module collision_matrix (
	input game_pkg::layer_req_t sampled,
	input logic [1:0] invulnerable, // bit 0 player1, bit 1 player2
	output game_pkg::event_t events
);

	logic any_blast;
	logic any_enemy;
	logic solid;          // columns or wall
	logic enemy_obstacle; // what stops an enemy
	logic open_floor;     // no wall on this pixel
	logic danger;         // anything that hurts a player

	assign any_blast = sampled.blast1 | sampled.blast2;
	assign any_enemy = sampled.enemy1 | sampled.enemy2 | sampled.enemy3;
	assign solid = sampled.columns | sampled.wall;
	assign enemy_obstacle = solid | sampled.bomb1 | sampled.bomb2;
	assign open_floor = ~sampled.wall;
	assign danger = any_blast | any_enemy | sampled.spikes;

	always_comb begin
		events = '0;

		// a player can walk over its own bomb but not the other one's
		events.player1_blocked = sampled.player1 & (solid | sampled.bomb2);
		events.player2_blocked = sampled.player2 & (solid | sampled.bomb1);

		// enemies are stopped by either bomb
		events.enemy1_blocked = sampled.enemy1 & enemy_obstacle;
		events.enemy2_blocked = sampled.enemy2 & enemy_obstacle;
		events.enemy3_blocked = sampled.enemy3 & enemy_obstacle;
		events.enemy_blocked_any = events.enemy1_blocked
			| events.enemy2_blocked
			| events.enemy3_blocked;

		// columns are indestructible, only plain wall counts
		events.blast_wall = any_blast & sampled.wall & ~sampled.columns;

		// door and power-up hidden behind a wall are not reachable yet
		events.player1_door = sampled.player1 & sampled.door_idol & open_floor;
		events.player1_powerup = sampled.player1 & sampled.powerup & open_floor;
		events.player2_powerup = sampled.player2 & sampled.powerup & open_floor;

		events.player1_hit = sampled.player1 & danger & ~invulnerable[0];
		events.player2_hit = sampled.player2 & danger & ~invulnerable[1];

		// any blast kills, no matter who laid the bomb
		events.enemy1_kill = any_blast & sampled.enemy1;
		events.enemy2_kill = any_blast & sampled.enemy2;
		events.enemy3_kill = any_blast & sampled.enemy3;

		events.spare = 1'b0;
	end

endmodule

`default_nettype wire

//--- frame_event_latch.sv
/*
  turns raw per-pixel events into one pulse per event per frame
  and keeps the last-frame summary and the frame counter for the host
*/
`timescale 1ns/1ns
`default_nettype none

module frame_event_latch (
	input logic clk,
	input logic resetN,
	input game_pkg::event_t events,
	input logic frame_start,
	output game_pkg::event_t event_pulse,
	output game_pkg::event_t last_events,
	output game_pkg::frame_count_t frame_count
);

	import game_pkg::*;

	event_t seen;  // events already reported in the current frame
	event_t prior; // accumulator as the current pixel sees it
	event_t fresh; // first occurrences on this pixel

	// at frame_start the pixel already belongs to the new frame,
	// so it is compared against an empty accumulator
	assign prior = frame_start ? event_t'('0) : seen;
	assign fresh = events & ~prior;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			seen <= '0;
			event_pulse <= '0;
			last_events <= '0;
			frame_count <= '0;
		end
		else begin
			event_pulse <= fresh;       // single cycle, cleared next pixel unless new
			seen <= prior | events;

			if (frame_start) begin
				last_events <= seen;     // summary of the frame just ended
				frame_count <= frame_count + 1'b1; // wraps at full scale
			end
		end
	end

endmodule

`default_nettype wire

//--- wb_status_regs.sv
/*
  wishbone classic slave for the host, one wait-free ack per request
  holds the invulnerability control and reads back summary and frame count
*/
`timescale 1ns/1ns
`default_nettype none

module wb_status_regs (
	input logic clk,
	input logic resetN,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input game_pkg::wb_addr_t wb_adr,
	input game_pkg::wb_data_t wb_dat_w,
	output game_pkg::wb_data_t wb_dat_r,
	output logic wb_ack,
	input game_pkg::event_t last_events,
	input game_pkg::frame_count_t frame_count,
	output logic [1:0] invulnerable
);

	import game_pkg::*;

	logic request;   // valid classic cycle
	logic accept;    // request taken on this edge
	wb_data_t rd_mux;

	assign request = wb_cyc & wb_stb;

	// no ack in the cycle after an ack, so a held stb is not acked twice
	assign accept = request & ~wb_ack;

	// register read decode
	always_comb begin
		case (wb_adr)
			REG_CONTROL: rd_mux = {{(WB_DATA_W - CTRL_BITS){1'b0}}, invulnerable};
			REG_LAST_EVENTS: rd_mux = last_events;
			REG_FRAME_COUNT: rd_mux = frame_count;
			default: rd_mux = '0; // unmapped
		endcase
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			wb_ack <= 1'b0;
			invulnerable <= '0;
		end
		else begin
			wb_ack <= accept; // one clock after the request

			// writes elsewhere are acked and dropped
			if (accept && wb_we && wb_adr == REG_CONTROL)
				invulnerable <= wb_dat_w[CTRL_BITS-1:0];
		end
	end

	// read data is captured with the ack and held until the next read
	always_ff @(posedge clk) begin
		if (accept && !wb_we)
			wb_dat_r <= rd_mux;
	end

endmodule

`default_nettype wire

//--- collision_top.sv
/*
  collision subsystem top, pixel requests in, event pulses out
  sampler feeds the rule matrix, the latch feeds the game and the host registers
*/
`timescale 1ns/1ns
`default_nettype none

module collision_top (
	input logic clk,
	input logic resetN,
	input logic player1,
	input logic player2,
	input logic columns,
	input logic wall,
	input logic blast1,
	input logic blast2,
	input logic enemy1,
	input logic enemy2,
	input logic enemy3,
	input logic bomb1,
	input logic bomb2,
	input logic door_idol,
	input logic powerup,
	input logic spikes,
	input logic start_of_frame,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input game_pkg::wb_addr_t wb_adr,
	input game_pkg::wb_data_t wb_dat_w,
	output game_pkg::wb_data_t wb_dat_r,
	output logic wb_ack,
	output game_pkg::event_t event_pulse
);

	import game_pkg::*;

	layer_req_t layers;
	layer_req_t sampled;
	logic frame_start;
	logic [1:0] invulnerable;
	event_t events;
	event_t last_events;
	frame_count_t frame_count;

	assign layers = '{player1: player1, player2: player2, columns: columns, wall: wall,
		blast1: blast1, blast2: blast2, enemy1: enemy1, enemy2: enemy2, enemy3: enemy3,
		bomb1: bomb1, bomb2: bomb2, door_idol: door_idol, powerup: powerup,
		spikes: spikes};

	layer_sampler i_sampler (.clk, .resetN, .layers_in(layers), .start_of_frame,
		.sampled, .frame_start);

	collision_matrix i_matrix (.sampled, .invulnerable, .events);

	frame_event_latch i_latch (.clk, .resetN, .events, .frame_start, .event_pulse,
		.last_events, .frame_count);

	wb_status_regs i_regs (.clk, .resetN, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
		.wb_dat_r, .wb_ack, .last_events, .frame_count, .invulnerable);

endmodule

`default_nettype wire

//--- tb_clock.sv
/*
  free-running testbench clock, 4 ns period
*/
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
	output logic clk
);

	localparam int HALF_PERIOD = 2; // ns

	initial clk = 1'b0;

	always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

//--- collision_tb.sv
/*
  testbench for collision_top, random and directed pixels against a rule model
  plus wishbone reads and writes of the host registers, run as the simulation top
*/
`timescale 1ns/1ns
`default_nettype none

module collision_tb;

	import game_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int RANDOM_PIXELS = 300;
	localparam int RULE_FRAME = 25;  // pixels per frame in the rules test
	localparam int HOLD_PIXELS = 40;
	localparam int SHORT_FRAME = 30;
	localparam int BUS_OPS = 17;
	localparam int BUS_CYCLES = 4;   // request, ack, release and slack
	localparam int CYCLE_LIMIT = 2 * (RESET_CYCLES + RANDOM_PIXELS + 2 * HOLD_PIXELS
		+ 3 * SHORT_FRAME + BUS_OPS * BUS_CYCLES + 40);

	logic clk;
	logic resetN;
	layer_req_t layers;
	logic start_of_frame;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_addr_t wb_adr;
	wb_data_t wb_dat_w;
	wb_data_t wb_dat_r;
	logic wb_ack;
	event_t event_pulse;

	// reference model state
	event_t frame_acc;          // events of the frame being drawn
	event_t last_expected;      // summary of the frame before
	frame_count_t frames_expected;
	logic [1:0] invuln_model;
	event_t expected_q[$];      // expected pulses, two pixels in flight

	event_t observed_or;
	int p1_block_pulses;
	int checks;
	int errors;
	int cycle_count;
	integer seed;
	string test_name;
	wb_data_t rd;
	layer_req_t pix;

	tb_clock i_clock (.clk);

	collision_top i_dut (.clk, .resetN,
		.player1(layers.player1), .player2(layers.player2), .columns(layers.columns),
		.wall(layers.wall), .blast1(layers.blast1), .blast2(layers.blast2),
		.enemy1(layers.enemy1), .enemy2(layers.enemy2), .enemy3(layers.enemy3),
		.bomb1(layers.bomb1), .bomb2(layers.bomb2), .door_idol(layers.door_idol),
		.powerup(layers.powerup), .spikes(layers.spikes), .start_of_frame,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack, .event_pulse);

	// reference model of the collision rules
	function automatic event_t rule_events(input layer_req_t p, input logic [1:0] inv);
		event_t e;
		logic blast;
		logic hurt;
		logic enemy_stop;
		e = '0;
		blast = p.blast1 || p.blast2;
		hurt = blast || p.enemy1 || p.enemy2 || p.enemy3 || p.spikes;
		enemy_stop = p.columns || p.wall || p.bomb1 || p.bomb2;
		e.player1_blocked = p.player1 && (p.columns || p.wall || p.bomb2);
		e.player2_blocked = p.player2 && (p.columns || p.wall || p.bomb1);
		e.enemy1_blocked = p.enemy1 && enemy_stop;
		e.enemy2_blocked = p.enemy2 && enemy_stop;
		e.enemy3_blocked = p.enemy3 && enemy_stop;
		e.enemy_blocked_any = e.enemy1_blocked || e.enemy2_blocked || e.enemy3_blocked;
		e.blast_wall = blast && p.wall && !p.columns;
		e.player1_door = p.player1 && p.door_idol && !p.wall;
		e.player1_powerup = p.player1 && p.powerup && !p.wall;
		e.player2_powerup = p.player2 && p.powerup && !p.wall;
		e.player1_hit = p.player1 && hurt && !inv[0];
		e.player2_hit = p.player2 && hurt && !inv[1];
		e.enemy1_kill = blast && p.enemy1;
		e.enemy2_kill = blast && p.enemy2;
		e.enemy3_kill = blast && p.enemy3;
		return e;
	endfunction

	// drives one pixel on the rising edge and updates the frame model
	task automatic drive_pixel(input layer_req_t p, input logic sof);
		event_t now;
		@(posedge clk);
		layers <= p;
		start_of_frame <= sof;
		if (sof) begin
			last_expected = frame_acc;
			frame_acc = '0; // this pixel already belongs to the new frame
			frames_expected = frames_expected + 16'd1;
		end
		now = rule_events(p, invuln_model);
		expected_q.push_back(now & ~frame_acc);
		frame_acc = frame_acc | now;
	endtask

	// event_pulse at the falling edge belongs to the pixel driven two edges ago
	task automatic check_pulse();
		event_t exp;
		@(negedge clk);
		exp = expected_q.pop_front();
		checks++;
		observed_or = observed_or | event_pulse;
		if (event_pulse.player1_blocked)
			p1_block_pulses++;
		assert (event_pulse === exp) else begin
			errors++;
			$display("MISMATCH %s event_pulse expected %h actual %h", test_name, exp,
				event_pulse);
		end
	endtask

	task automatic idle_pixels(input int n);
		repeat (n) begin
			drive_pixel('0, 1'b0);
			check_pulse();
		end
	endtask

	task automatic random_pixel(input logic sof);
		logic [31:0] rnd;
		rnd = $random(seed) & $random(seed); // about one layer in four is drawn
		drive_pixel(layer_req_t'(rnd[13:0]), sof);
		check_pulse();
	endtask

	task automatic compare_value(input string what, input wb_data_t expected,
		input wb_data_t actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("MISMATCH %s %s expected %h actual %h", test_name, what, expected,
				actual);
		end
	endtask

	// one classic cycle, pixels stay idle while the bus is busy
	task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t wdata,
		output wb_data_t rdata);
		int waited;
		drive_pixel('0, 1'b0);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= adr;
		wb_dat_w <= wdata;
		check_pulse();
		waited = 0;
		do begin
			drive_pixel('0, 1'b0);
			check_pulse();
			waited++;
		end while (!wb_ack && waited < BUS_CYCLES);
		checks++;
		assert (wb_ack === 1'b1 && waited == 1) else begin
			errors++;
			$display("%s: ack for address %0d not seen one cycle after the request",
				test_name, adr);
		end
		rdata = wb_dat_r;
		drive_pixel('0, 1'b0);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
		check_pulse();
	endtask

	task automatic read_reg(input wb_addr_t adr, output wb_data_t rdata);
		bus_access(1'b0, adr, '0, rdata);
	endtask

	task automatic write_reg(input wb_addr_t adr, input wb_data_t wdata);
		wb_data_t unused;
		bus_access(1'b1, adr, wdata, unused);
	endtask

	initial begin
		seed = 32'hb90d_f5f1;
		resetN = 1'b0;
		layers = '0;
		start_of_frame = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		frame_acc = '0;
		last_expected = '0;
		frames_expected = '0;
		invuln_model = '0;
		observed_or = '0;
		p1_block_pulses = 0;
		checks = 0;
		errors = 0;
		expected_q.push_back('0);
		expected_q.push_back('0);

		test_name = "reset";
		repeat (RESET_CYCLES) @(posedge clk);
		resetN <= 1'b1;
		@(negedge clk);
		compare_value("event_pulse", '0, event_pulse);
		compare_value("wb_ack", '0, {15'd0, wb_ack});
		read_reg(REG_CONTROL, rd);
		compare_value("control", '0, rd);
		read_reg(REG_LAST_EVENTS, rd);
		compare_value("last_events", '0, rd);
		read_reg(REG_FRAME_COUNT, rd);
		compare_value("frame_count", '0, rd);

		test_name = "rules";
		for (int i = 0; i < RANDOM_PIXELS; i++)
			random_pixel(i % RULE_FRAME == 0); // short frames keep every rule in play
		idle_pixels(2);

		test_name = "once_per_frame";
		pix = '0;
		pix.player1 = 1'b1;
		pix.wall = 1'b1;
		p1_block_pulses = 0;
		for (int f = 1; f <= 2; f++) begin
			for (int i = 0; i < HOLD_PIXELS; i++) begin
				drive_pixel(pix, i == 0);
				check_pulse();
			end
			idle_pixels(2);
			compare_value("player1_blocked pulses", wb_data_t'(f),
				wb_data_t'(p1_block_pulses));
		end

		test_name = "summary";
		for (int f = 0; f < 3; f++) begin
			drive_pixel('0, 1'b1);
			check_pulse();
			idle_pixels(2); // summary settles two edges after start_of_frame
			read_reg(REG_LAST_EVENTS, rd);
			compare_value("last_events", last_expected, rd);
			read_reg(REG_FRAME_COUNT, rd);
			compare_value("frame_count", frames_expected, rd);
			for (int i = 0; i < SHORT_FRAME; i++)
				random_pixel(1'b0);
		end

		test_name = "invulnerability";
		write_reg(REG_CONTROL, 16'hfffd);
		invuln_model = 2'b01;
		read_reg(REG_CONTROL, rd);
		compare_value("control", 16'h0001, rd);
		drive_pixel('0, 1'b1); // new frame so both hits may pulse
		check_pulse();
		observed_or = '0;
		pix = '0;
		pix.player1 = 1'b1;
		pix.player2 = 1'b1;
		pix.enemy1 = 1'b1;
		drive_pixel(pix, 1'b0);
		check_pulse();
		idle_pixels(2);
		compare_value("player1_hit", 16'd0, {15'd0, observed_or.player1_hit});
		compare_value("player2_hit", 16'd1, {15'd0, observed_or.player2_hit});
		write_reg(REG_CONTROL, 16'h0000);
		invuln_model = 2'b00;
		read_reg(REG_CONTROL, rd);
		compare_value("control", 16'h0000, rd);

		test_name = "read_only_write";
		read_reg(REG_FRAME_COUNT, rd);
		compare_value("frame_count before", frames_expected, rd);
		write_reg(REG_FRAME_COUNT, ~rd);
		read_reg(REG_FRAME_COUNT, rd);
		compare_value("frame_count after", frames_expected, rd);
		read_reg(REG_CONTROL, rd); // the ignored write must not reach the control bits
		compare_value("control after", 16'h0000, rd);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end
		else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
game_pkg.sv
layer_sampler.sv
collision_matrix.sv
frame_event_latch.sv
wb_status_regs.sv
collision_top.sv
tb_clock.sv
collision_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = collision_tb
FILELIST = project.f
LOG = sim.log
FAIL_MSG = Simulation finished: FAIL
PASS_MSG = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
